// ==== cart_top.f ====
cart_map_pkg.sv
snes_bus_sync.sv
snes_address_map.sv
sram_access_seq.sv
snes_data_return.sv
cart_top.sv
tb_clkgen.sv
tb_sram_model.sv
tb_cart_top.sv

// ==== tb_cart_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cart_top import cart_map_pkg::*; ();

  localparam int WAIT_CYCLES    = 3;
  localparam int STROBE_CYCLES  = 24;
  // 6 tests, up to 40 bus cycles each, 30 clocks per bus cycle
  localparam int TIMEOUT_CYCLES = 6 * 40 * 30;

  logic        clk;
  logic        rst_n;
  map_cfg_t    cfg;
  logic        rd_n, wr_n, pard_n, pawr_n;
  logic [23:0] snes_addr;
  logic [7:0]  snes_pa;
  logic [7:0]  snes_data_in;
  wire  [7:0]  snes_data_out;
  wire         snes_data_oe;
  wire  [23:0] sram_addr;
  wire  [7:0]  sram_wdata;
  wire  [7:0]  sram_rdata;
  wire         sram_oe_n, sram_we_n;
  wire         msu_sel, srtc_sel, dspx_sel, dspx_a0, r213f_sel;
  int          write_count;

  // what one bus cycle left behind
  logic        seen_access;
  logic [23:0] seen_addr;
  logic        seen_oe;
  logic [7:0]  seen_data;
  int          first_oe;
  map_result_t seen_sel;

  int errors;
  int n_pass;
  int n_fail;
  int cycles;

  tb_clkgen u_clk (.clk(clk));

  cart_top #(.WAIT_CYCLES(WAIT_CYCLES)) uut (
    .clk(clk), .rst_n(rst_n), .cfg(cfg),
    .rd_n(rd_n), .wr_n(wr_n), .pard_n(pard_n), .pawr_n(pawr_n),
    .snes_addr(snes_addr), .snes_pa(snes_pa), .snes_data_in(snes_data_in),
    .snes_data_out(snes_data_out), .snes_data_oe(snes_data_oe),
    .sram_addr(sram_addr), .sram_wdata(sram_wdata), .sram_rdata(sram_rdata),
    .sram_oe_n(sram_oe_n), .sram_we_n(sram_we_n),
    .msu_sel(msu_sel), .srtc_sel(srtc_sel), .dspx_sel(dspx_sel),
    .dspx_a0(dspx_a0), .r213f_sel(r213f_sel)
  );

  tb_sram_model u_sram (
    .clk(clk), .addr(sram_addr), .wdata(sram_wdata), .rdata(sram_rdata),
    .oe_n(sram_oe_n), .we_n(sram_we_n), .write_count(write_count)
  );

  // run limit
  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout, run stopped after %0d clock cycles", cycles);
      $display("** FAIL **");
      $finish;
    end
  end

  ////////////////////////////////////////
  // expected values
  ////////////////////////////////////////

  function automatic logic [7:0] fill_byte(input logic [23:0] a);
    return a[7:0] ^ a[15:8];
  endfunction

  function automatic logic [23:0] hirom_addr(input logic [23:0] a, input logic [23:0] m);
    return {1'b0, a[22:0]} & m;
  endfunction

  function automatic logic [23:0] lorom_addr(input logic [23:0] a, input logic [23:0] m);
    return {2'b00, a[22:16], a[14:0]} & m;
  endfunction

  function automatic logic [23:0] save_addr(input logic [23:0] a, input logic [23:0] m);
    return 24'hE00000 + ({4'h0, a[20:16], a[14:0]} & m);
  endfunction

  // select lines for hirom and small lorom carts
  function automatic map_result_t sel_expect(input logic bbus, input logic [23:0] a,
                                             input logic [7:0] pa);
    map_result_t r;
    logic        dsp_on;
    r = '0;
    r.dspx_a0 = 1'b1;
    dsp_on = !bbus && cfg.featurebits[feat_dspx];
    if (!bbus) begin
      r.msu_sel = cfg.featurebits[feat_msu1] && !a[22]
                  && a[15:0] >= 16'h2000 && a[15:0] <= 16'h2007;
      r.srtc_sel = cfg.featurebits[feat_srtc] && !a[22]
                   && a[15:0] >= 16'h2800 && a[15:0] <= 16'h2801;
    end
    if (dsp_on && cfg.mapper == map_hirom) begin
      r.dspx_sel = a[22:16] < 7'h10 && a[15:0] >= 16'h6000 && a[15:0] <= 16'h7FFF;
      r.dspx_a0  = a[12];
    end
    if (dsp_on && cfg.mapper == map_lorom) begin
      r.dspx_sel = a[22:16] >= 7'h30 && a[22:16] <= 7'h3F && a[15];
      r.dspx_a0  = a[14];
    end
    r.r213f_sel = bbus && cfg.featurebits[feat_213f] && pa == 8'h3F;
    return r;
  endfunction

  ////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////

  task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      errors++;
      $display("ERROR %0t: %s data %02h, expected %02h", $time, what, got, exp);
    end
  endtask

  task automatic check_addr(input string what, input logic [23:0] got,
                            input logic [23:0] exp);
    if (got !== exp) begin
      errors++;
      $display("ERROR %0t: %s sram_addr %06h, expected %06h", $time, what, got, exp);
    end
  endtask

  task automatic check_result(input string what, input map_result_t got,
                              input map_result_t exp);
    logic [4:0] g;
    logic [4:0] e;
    g = {got.msu_sel, got.srtc_sel, got.dspx_sel, got.dspx_a0, got.r213f_sel};
    e = {exp.msu_sel, exp.srtc_sel, exp.dspx_sel, exp.dspx_a0, exp.r213f_sel};
    if (g !== e) begin
      errors++;
      $display("ERROR %0t: %s msu/srtc/dspx/a0/213f %05b, expected %05b", $time, what, g, e);
    end
  endtask

  ////////////////////////////////////////
  // bus driving
  ////////////////////////////////////////

  task automatic set_cfg(input mapper_e m, input logic [7:0] fb, input logic [23:0] rm,
                         input logic [23:0] sm);
    cfg.mapper       = m;
    cfg.featurebits  = fb;
    cfg.rom_mask     = rm;
    cfg.saveram_mask = sm;
  endtask

  // one snes cycle, strobe low for 24 clocks
  task automatic bus_cycle(input logic bbus, input logic write, input logic [23:0] addr,
                           input logic [7:0] pa, input logic [7:0] wdata);
    int i;
    seen_access = 1'b0;
    seen_oe     = 1'b0;
    first_oe    = -1;
    @(posedge clk);
    #1;
    snes_addr    = addr;
    snes_pa      = pa;
    snes_data_in = wdata;
    if (bbus && write) pawr_n = 1'b0;
    else if (bbus) pard_n = 1'b0;
    else if (write) wr_n = 1'b0;
    else rd_n = 1'b0;
    for (i = 0; i < STROBE_CYCLES; i++) begin
      // sample mid cycle, away from the drive edge
      @(negedge clk);
      if (!seen_access && (!sram_oe_n || !sram_we_n)) begin
        seen_access = 1'b1;
        seen_addr   = sram_addr;
      end
      if (snes_data_oe && first_oe < 0) first_oe = i;
      if (i == STROBE_CYCLES - 1) begin
        seen_oe   = snes_data_oe;
        seen_data = snes_data_out;
        seen_sel  = '0;
        seen_sel.msu_sel   = msu_sel;
        seen_sel.srtc_sel  = srtc_sel;
        seen_sel.dspx_sel  = dspx_sel;
        seen_sel.dspx_a0   = dspx_a0;
        seen_sel.r213f_sel = r213f_sel;
      end
      @(posedge clk);
      #1;
    end
    rd_n   = 1'b1;
    wr_n   = 1'b1;
    pard_n = 1'b1;
    pawr_n = 1'b1;
    // bus idle gap
    repeat (6) @(posedge clk);
    #1;
  endtask

  // data bus driven, in time, with the right byte
  task automatic data_check(input string what, input logic [7:0] exp);
    if (!seen_oe) begin
      errors++;
      $display("%s: the cart never drove the data bus", what);
    end else begin
      check_byte(what, seen_data, exp);
      if (first_oe > 5 + WAIT_CYCLES) begin
        errors++;
        $display("%s: data came %0d cycles after the strobe, too late", what, first_oe);
      end
    end
  endtask

  task automatic read_check(input string what, input logic [23:0] addr,
                            input logic [23:0] exp_addr, input logic [7:0] exp_data);
    bus_cycle(1'b0, 1'b0, addr, 8'h00, 8'h00);
    if (!seen_access) begin
      errors++;
      $display("%s: no SRAM read was started", what);
    end else begin
      check_addr(what, seen_addr, exp_addr);
    end
    data_check(what, exp_data);
  endtask

  task automatic write_check(input string what, input logic [23:0] addr, input logic [7:0] d,
                             input logic [23:0] exp_addr);
    int c0;
    c0 = write_count;
    bus_cycle(1'b0, 1'b1, addr, 8'h00, d);
    if (!seen_access) begin
      errors++;
      $display("%s: no SRAM write was started", what);
    end else begin
      check_addr(what, seen_addr, exp_addr);
    end
    if (write_count != c0 + 1) begin
      errors++;
      $display("%s: SRAM saw %0d writes instead of one", what, write_count - c0);
    end
  endtask

  task automatic end_test(input string name, input int e0);
    if (errors == e0) begin
      n_pass++;
      $display("%-14s ok", name);
    end else begin
      n_fail++;
      $display("%-14s failed with %0d errors", name, errors - e0);
    end
  endtask

  ////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////

  task automatic test_rom_reads();
    int          e0;
    int          k;
    logic [23:0] a;
    e0 = errors;
    set_cfg(map_lorom, 8'h00, 24'h3FFFFF, 24'h001FFF);
    for (k = 0; k < 4; k++) begin
      a = 24'($urandom);
      // upper half of the bank is always rom
      a[15] = 1'b1;
      read_check("lorom read", a, lorom_addr(a, 24'h3FFFFF),
                 fill_byte(lorom_addr(a, 24'h3FFFFF)));
    end
    set_cfg(map_hirom, 8'h00, 24'h3FFFFF, 24'h001FFF);
    for (k = 0; k < 4; k++) begin
      a = 24'($urandom);
      a[22] = 1'b1;
      read_check("hirom read", a, hirom_addr(a, 24'h3FFFFF),
                 fill_byte(hirom_addr(a, 24'h3FFFFF)));
    end
    end_test("rom_reads", e0);
  endtask

  task automatic test_saveram();
    int e0;
    int c0;
    e0 = errors;
    set_cfg(map_hirom, 8'h00, 24'h3FFFFF, 24'h001FFF);
    write_check("hirom sram wr", 24'h306123, 8'h5A, save_addr(24'h306123, 24'h001FFF));
    read_check("hirom sram rd", 24'h306123, 24'hE00123, 8'h5A);
    // rom is never written
    c0 = write_count;
    bus_cycle(1'b0, 1'b1, 24'hC01234, 8'h00, 8'hEE);
    if (write_count != c0 || seen_access) begin
      errors++;
      $display("rom write: a write to ROM reached the SRAM");
    end
    end_test("saveram", e0);
  endtask

  task automatic test_masks();
    int e0;
    e0 = errors;
    set_cfg(map_hirom, 8'h00, 24'h07FFFF, 24'h0007FF);
    read_check("hirom masked", 24'hD5ABCD, 24'h05ABCD, fill_byte(24'h05ABCD));
    write_check("sram masked wr", 24'h216805, 8'hC3, 24'hE00005);
    // other bank, same wrapped offset
    read_check("sram alias rd", 24'h206005, 24'hE00005, 8'hC3);
    set_cfg(map_lorom, 8'h00, 24'h07FFFF, 24'h0007FF);
    read_check("lorom masked", 24'h3FFFFF, 24'h07FFFF, fill_byte(24'h07FFFF));
    end_test("masks", e0);
  endtask

  task automatic test_exhi_menu();
    int e0;
    e0 = errors;
    set_cfg(map_exhirom, 8'h00, 24'hFFFFFF, 24'h001FFF);
    read_check("exhirom c0", 24'hC01234, 24'h001234, fill_byte(24'h001234));
    read_check("exhirom 40", 24'h401234, 24'h401234, fill_byte(24'h401234));
    set_cfg(map_menu, 8'h00, 24'h3FFFFF, 24'h001FFF);
    read_check("menu rom", 24'hC12345, 24'hC12345, fill_byte(24'hC12345));
    write_check("menu sram wr", 24'h206010, 8'h77, 24'hFF0010);
    read_check("menu sram rd", 24'h206010, 24'hFF0010, 8'h77);
    end_test("exhirom_menu", e0);
  endtask

  task automatic sel_check(input string what, input logic bbus, input logic [23:0] a,
                           input logic [7:0] pa);
    bus_cycle(bbus, 1'b0, a, pa, 8'h00);
    check_result(what, seen_sel, sel_expect(bbus, a, pa));
  endtask

  task automatic test_selects();
    int         e0;
    int         k;
    logic [7:0] fb;
    e0 = errors;
    for (k = 0; k < 2; k++) begin
      // first all features on, then all off
      fb = (k == 0) ? 8'h1D : 8'h00;
      set_cfg(map_hirom, fb, 24'h0FFFFF, 24'h001FFF);
      sel_check("msu 2004", 1'b0, 24'h002004, 8'h00);
      sel_check("msu 2008", 1'b0, 24'h002008, 8'h00);
      sel_check("srtc 2801", 1'b0, 24'h002801, 8'h00);
      sel_check("dsp hi 6000", 1'b0, 24'h006000, 8'h00);
      sel_check("dsp hi 7000", 1'b0, 24'h007000, 8'h00);
      sel_check("dsp hi 106000", 1'b0, 24'h106000, 8'h00);
      sel_check("213f", 1'b1, 24'h000000, 8'h3F);
      sel_check("213e", 1'b1, 24'h000000, 8'h3E);
      set_cfg(map_lorom, fb, 24'h0FFFFF, 24'h001FFF);
      sel_check("dsp lo c000", 1'b0, 24'h30C000, 8'h00);
      sel_check("dsp lo 8000", 1'b0, 24'h308000, 8'h00);
    end
    end_test("selects", e0);
  endtask

  task automatic test_snescmd();
    int         e0;
    int         c0;
    int         i;
    logic [7:0] cmd [16];
    e0 = errors;
    set_cfg(map_hirom, 8'h00, 24'h3FFFFF, 24'h001FFF);
    c0 = write_count;
    for (i = 0; i < 16; i++) begin
      cmd[i] = 8'($urandom);
      bus_cycle(1'b0, 1'b1, 24'hCCCCC0 + 24'(i), 8'h00, cmd[i]);
      if (seen_access) begin
        errors++;
        $display("snescmd write %0d: the write reached the SRAM", i);
      end
    end
    if (write_count != c0) begin
      errors++;
      $display("snescmd: SRAM write count changed by %0d", write_count - c0);
    end
    // read back in reverse order over the b-bus
    for (i = 15; i >= 0; i--) begin
      bus_cycle(1'b1, 1'b0, 24'h000000, 8'hF0 + 8'(i), 8'h00);
      data_check($sformatf("snescmd rd %0d", i), cmd[i]);
    end
    end_test("snescmd", e0);
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    rst_n        = 1'b0;
    rd_n         = 1'b1;
    wr_n         = 1'b1;
    pard_n       = 1'b1;
    pawr_n       = 1'b1;
    snes_addr    = '0;
    snes_pa      = '0;
    snes_data_in = '0;
    cfg          = '0;
    errors       = 0;
    n_pass       = 0;
    n_fail       = 0;
    cycles       = 0;
    void'($urandom(68760));
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;
    repeat (4) @(posedge clk);
    #1;
    test_rom_reads();
    test_saveram();
    test_masks();
    test_exhi_menu();
    test_selects();
    test_snescmd();
    $display("tests passed %0d, failed %0d", n_pass, n_fail);
    if (n_fail == 0 && errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb_sram_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_sram_model (
  input  wire        clk,
  input  wire [23:0] addr,
  input  wire [7:0]  wdata,
  output logic [7:0] rdata,
  input  wire        oe_n,
  input  wire        we_n,
  output int         write_count
);

  // only bytes that were written are stored
  logic [7:0] written [int];
  logic       we_q;

  // untouched bytes read as low byte xor middle byte
  function automatic logic [7:0] fill_byte(input logic [23:0] a);
    return a[7:0] ^ a[15:8];
  endfunction

  initial begin
    write_count = 0;
    we_q        = 1'b1;
    rdata       = 8'h00;
  end

  // one clock read latency while oe is low
  always @(posedge clk) begin
    if (!oe_n) begin
      if (written.exists(int'(addr))) begin
        rdata <= written[int'(addr)];
      end else begin
        rdata <= fill_byte(addr);
      end
    end
    if (!we_n) begin
      written[int'(addr)] = wdata;
      // one count per write strobe, not per cycle
      if (we_q) begin
        write_count <= write_count + 1;
      end
    end
    we_q <= we_n;
  end

endmodule

`default_nettype wire

// ==== tb_clkgen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
  parameter real PERIOD_NS = 4.0
) (
  output logic clk
);

  // free running, starts low
  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD_NS / 2.0);
      clk = ~clk;
    end
  end

endmodule

`default_nettype wire

// ==== cart_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cart_top import cart_map_pkg::*; #(
  parameter int WAIT_CYCLES = 3
) (
  input  wire        clk,
  input  wire        rst_n,
  input  map_cfg_t   cfg,
  input  wire        rd_n,
  input  wire        wr_n,
  input  wire        pard_n,
  input  wire        pawr_n,
  input  wire [23:0] snes_addr,
  input  wire [7:0]  snes_pa,
  input  wire [7:0]  snes_data_in,
  output wire [7:0]  snes_data_out,
  output wire        snes_data_oe,
  output wire [23:0] sram_addr,
  output wire [7:0]  sram_wdata,
  input  wire [7:0]  sram_rdata,
  output wire        sram_oe_n,
  output wire        sram_we_n,
  output wire        msu_sel,
  output wire        srtc_sel,
  output wire        dspx_sel,
  output wire        dspx_a0,
  output wire        r213f_sel
);

  snes_req_t   req;
  wire         req_valid;
  wire         rd_active;
  map_result_t map;
  wire         map_valid;
  wire [7:0]   rdata;
  wire         rd_done;

  ////////////////////////////////////////
  // decode
  ////////////////////////////////////////

  snes_bus_sync u_sync (
    .clk          (clk),
    .rst_n        (rst_n),
    .rd_n         (rd_n),
    .wr_n         (wr_n),
    .pard_n       (pard_n),
    .pawr_n       (pawr_n),
    .snes_addr    (snes_addr),
    .snes_pa      (snes_pa),
    .snes_data_in (snes_data_in),
    .req          (req),
    .req_valid    (req_valid),
    .rd_active    (rd_active)
  );

  snes_address_map u_map (
    .clk       (clk),
    .rst_n     (rst_n),
    .cfg       (cfg),
    .req       (req),
    .req_valid (req_valid),
    .map       (map),
    .map_valid (map_valid)
  );

  // execute
  sram_access_seq #(
    .WAIT_CYCLES (WAIT_CYCLES)
  ) u_seq (
    .clk        (clk),
    .rst_n      (rst_n),
    .map        (map),
    .map_valid  (map_valid),
    .req        (req),
    .sram_addr  (sram_addr),
    .sram_wdata (sram_wdata),
    .sram_rdata (sram_rdata),
    .sram_oe_n  (sram_oe_n),
    .sram_we_n  (sram_we_n),
    .rdata      (rdata),
    .rd_done    (rd_done)
  );

  // result
  snes_data_return u_ret (
    .clk           (clk),
    .rst_n         (rst_n),
    .map           (map),
    .map_valid     (map_valid),
    .req           (req),
    .rdata         (rdata),
    .rd_done       (rd_done),
    .rd_active     (rd_active),
    .snes_data_out (snes_data_out),
    .snes_data_oe  (snes_data_oe)
  );

  // peripheral selects straight from the held map result
  assign msu_sel   = map.msu_sel;
  assign srtc_sel  = map.srtc_sel;
  assign dspx_sel  = map.dspx_sel;
  assign dspx_a0   = map.dspx_a0;
  assign r213f_sel = map.r213f_sel;

endmodule

`default_nettype wire

// ==== snes_data_return.sv ====
`timescale 1ns/1ps
`default_nettype none

module snes_data_return import cart_map_pkg::*; (
  input  wire         clk,
  input  wire         rst_n,
  input  map_result_t map,
  input  wire         map_valid,
  input  snes_req_t   req,
  input  wire  [7:0]  rdata,
  input  wire         rd_done,
  input  wire         rd_active,
  output logic [7:0]  snes_data_out,
  output logic        snes_data_oe
);

  // snescmd area, 16 bytes
  logic [7:0] cmd_mem [16];
  logic [7:0] cmd_q;
  logic       sram_pend;
  logic       serve_q;
  logic       src_cmd;
  logic       cmd_rd;
  logic       sram_rd;

  assign cmd_rd  = map_valid & map.cmd_rd_sel & ~req.is_write;
  assign sram_rd = map_valid & ~req.is_bbus & ~req.is_write
                   & (map.is_rom | map.is_saveram);

  // snescmd writes and read latch
  always_ff @(posedge clk) begin
    if (map_valid && map.cmd_wr_sel && req.is_write) begin
      cmd_mem[req.addr[3:0]] <= req.wdata;
    end
    if (cmd_rd) begin
      cmd_q <= cmd_mem[req.pa[3:0]];
    end
  end

  ////////////////////////////////////////
  // output enable tracking
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sram_pend <= 1'b0;
      serve_q   <= 1'b0;
      src_cmd   <= 1'b0;
    end else begin
      if (sram_rd) begin
        sram_pend <= 1'b1;
        src_cmd   <= 1'b0;
      end else if (rd_done) begin
        sram_pend <= 1'b0;
      end
      if (cmd_rd) begin
        // snescmd is ready right away
        serve_q <= 1'b1;
        src_cmd <= 1'b1;
      end else if (rd_done && sram_pend) begin
        serve_q <= 1'b1;
      end else if (!rd_active) begin
        // read strobe went back high
        serve_q <= 1'b0;
      end
    end
  end

  // sram data passes the cycle rd_done arrives
  assign snes_data_oe  = serve_q | (rd_done & sram_pend);
  assign snes_data_out = src_cmd ? cmd_q : rdata;

  // oe drops within a cycle of the strobe release
  a_oe_in_read: assert property (@(posedge clk) disable iff (!rst_n)
    !rd_active |=> !snes_data_oe);

endmodule

`default_nettype wire

// ==== sram_access_seq.sv ====
`timescale 1ns/1ps
`default_nettype none

module sram_access_seq import cart_map_pkg::*; #(
  parameter int WAIT_CYCLES = 3
) (
  input  wire         clk,
  input  wire         rst_n,
  input  map_result_t map,
  input  wire         map_valid,
  input  snes_req_t   req,
  output logic [23:0] sram_addr,
  output logic [7:0]  sram_wdata,
  input  wire  [7:0]  sram_rdata,
  output logic        sram_oe_n,
  output logic        sram_we_n,
  output logic [7:0]  rdata,
  output logic        rd_done
);

  seq_state_e state;
  logic [3:0] wait_cnt;
  logic       start_rd;
  logic       start_wr;

  // only a-bus cycles reach the sram
  assign start_rd = map_valid & ~req.is_bbus & ~req.is_write
                    & (map.is_rom | map.is_saveram);
  assign start_wr = map_valid & ~req.is_bbus & req.is_write & map.is_writable;

  ////////////////////////////////////////
  // control FSM
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= seq_idle;
      wait_cnt  <= '0;
      sram_oe_n <= 1'b1;
      sram_we_n <= 1'b1;
      rd_done   <= 1'b0;
    end else begin
      rd_done <= 1'b0;
      case (state)
        seq_idle: begin
          if (start_rd || start_wr) begin
            state     <= seq_access;
            wait_cnt  <= 4'(WAIT_CYCLES - 1);
            sram_oe_n <= ~start_rd;
            sram_we_n <= ~start_wr;
          end
        end
        seq_access: begin
          if (wait_cnt == 4'd0) begin
            // last access cycle, release strobes
            state     <= seq_done;
            sram_oe_n <= 1'b1;
            sram_we_n <= 1'b1;
            rd_done   <= ~sram_oe_n;
          end else begin
            wait_cnt <= wait_cnt - 4'd1;
          end
        end
        seq_done: begin
          // one turnaround cycle
          state <= seq_idle;
        end
        default: begin
          state <= seq_idle;
        end
      endcase
    end
  end

  // address, write data and read data
  always_ff @(posedge clk) begin
    if (state == seq_idle && (start_rd || start_wr)) begin
      sram_addr  <= map.sram_addr;
      sram_wdata <= req.wdata;
    end
    if (state == seq_access && wait_cnt == 4'd0 && !sram_oe_n) begin
      rdata <= sram_rdata;
    end
  end

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  // bus contention on the sram data pins
  a_no_oe_we: assert property (@(posedge clk) disable iff (!rst_n)
    !(!sram_oe_n && !sram_we_n));

  // snes cycles are far apart, an overlap means lost requests
  a_idle_on_map: assert property (@(posedge clk) disable iff (!rst_n)
    map_valid |-> state == seq_idle);

endmodule

`default_nettype wire

// ==== snes_address_map.sv ====
`timescale 1ns/1ps
`default_nettype none

module snes_address_map import cart_map_pkg::*; (
  input  wire         clk,
  input  wire         rst_n,
  input  map_cfg_t    cfg,
  input  snes_req_t   req,
  input  wire         req_valid,
  output map_result_t map,
  output logic        map_valid
);

  map_result_t map_next;

  // shorthand for the captured address
  logic [23:0] a;
  logic        abus;
  logic        bbus;
  logic        mapped;
  logic        sav_hit;
  logic [23:0] sav_lin;
  logic [14:0] menu_off;
  logic [23:0] hirom_rom;
  logic        dspx_hit;

  assign a    = req.addr;
  assign bbus = req.is_bbus;
  assign abus = ~req.is_bbus;

  // bank bits 20:16 on top of the 32k offset
  assign sav_lin   = {4'h0, a[20:16], a[14:0]};
  // menu save ram starts at offset $6000
  assign menu_off  = a[14:0] - 15'h6000;
  assign hirom_rom = {1'b0, a[22:0]} & cfg.rom_mask;

  ////////////////////////////////////////
  // region and address decode
  ////////////////////////////////////////

  always_comb begin
    mapped   = 1'b1;
    sav_hit  = 1'b0;
    dspx_hit = 1'b0;
    map_next = '0;
    case (cfg.mapper)
      map_hirom: begin
        // sram @ 20-3f/a0-bf:6000-7fff
        sav_hit = ~a[22] & a[21] & &a[14:13] & ~a[15];
        map_next.sram_addr = hirom_rom;
        // dsp dr/sr @ 00-0f:6000-7fff
        dspx_hit = ~a[22] & ~a[21] & ~a[20] & ~a[15] & &a[14:13];
        map_next.dspx_a0 = a[12];
      end
      map_lorom: begin
        // sram @ 70-7d/f0-fd:0000-7fff
        sav_hit = &a[22:20] & (a[19:16] < 4'he) & ~a[15];
        map_next.sram_addr = {2'b00, a[22:16], a[14:0]} & cfg.rom_mask;
        // big roms push the dsp up to 60-6f
        if (cfg.rom_mask[20]) begin
          dspx_hit = a[22] & a[21] & ~a[20] & ~a[15];
        end else begin
          dspx_hit = ~a[22] & a[21] & a[20] & a[15];
        end
        map_next.dspx_a0 = a[14];
      end
      map_exhirom: begin
        sav_hit = ~a[22] & a[21] & &a[14:13] & ~a[15];
        // upper banks hold the first 32 mbit
        map_next.sram_addr = {1'b0, ~a[23], a[21:0]} & cfg.rom_mask;
        map_next.dspx_a0 = 1'b1;
      end
      map_menu: begin
        sav_hit = ~a[22] & a[21] & &a[14:13] & ~a[15];
        // menu rom lives in the top quarter of sram
        map_next.sram_addr = hirom_rom + 24'hC00000;
        map_next.dspx_a0 = 1'b1;
      end
      default: begin
        mapped = 1'b0;
        map_next.dspx_a0 = 1'b1;
      end
    endcase

    sav_hit = sav_hit & cfg.saveram_mask[0];

    // save ram overrides the rom address
    if (sav_hit) begin
      if (cfg.mapper == map_menu) begin
        map_next.sram_addr = 24'hFF0000 + ({9'h000, menu_off} & cfg.saveram_mask);
      end else begin
        map_next.sram_addr = 24'hE00000 + (sav_lin & cfg.saveram_mask);
      end
    end

    map_next.is_rom      = mapped & (a[22] | a[15]);
    map_next.is_saveram  = sav_hit;
    map_next.is_writable = sav_hit;

    ////////////////////////////////////////
    // peripheral selects
    ////////////////////////////////////////

    // msu-1 @ 2000-2007
    map_next.msu_sel  = abus & cfg.featurebits[feat_msu1] & ~a[22]
                        & (a[15:3] == 13'h0400);
    // s-rtc @ 2800-2801
    map_next.srtc_sel = abus & cfg.featurebits[feat_srtc] & ~a[22]
                        & (a[15:1] == 15'h1400);
    map_next.dspx_sel = abus & cfg.featurebits[feat_dspx] & dspx_hit;
    // a0 is a data/status line, idles high
    if (!(abus & cfg.featurebits[feat_dspx])) begin
      map_next.dspx_a0 = 1'b1;
    end
    map_next.r213f_sel  = bbus & cfg.featurebits[feat_213f] & (req.pa == 8'h3f);
    // snescmd read window $21f0-$21ff
    map_next.cmd_rd_sel = bbus & (req.pa[7:4] == 4'hf);
    // snescmd write window $cccccx
    map_next.cmd_wr_sel = abus & (a[23:4] == 20'hccccc);
  end

  ////////////////////////////////////////
  // result register
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      map       <= '0;
      map_valid <= 1'b0;
    end else begin
      map_valid <= req_valid;
      // held until the next request
      if (req_valid) begin
        map <= map_next;
      end
    end
  end

endmodule

`default_nettype wire

// ==== snes_bus_sync.sv ====
`timescale 1ns/1ps
`default_nettype none

module snes_bus_sync import cart_map_pkg::*; (
  input  wire        clk,
  input  wire        rst_n,
  input  wire        rd_n,
  input  wire        wr_n,
  input  wire        pard_n,
  input  wire        pawr_n,
  input  wire [23:0] snes_addr,
  input  wire [7:0]  snes_pa,
  input  wire [7:0]  snes_data_in,
  output snes_req_t  req,
  output logic       req_valid,
  output logic       rd_active
);

  // strobe order in the vectors below: {pawr, pard, wr, rd}
  logic [3:0] strb_s1;
  logic [3:0] strb_s2;
  logic [3:0] strb_s3;
  logic [3:0] strb_fall;

  ////////////////////////////////////////
  // strobe synchronizers
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // idle bus has all strobes high
      strb_s1 <= 4'hf;
      strb_s2 <= 4'hf;
      strb_s3 <= 4'hf;
    end else begin
      strb_s1 <= {pawr_n, pard_n, wr_n, rd_n};
      strb_s2 <= strb_s1;
      // s3 only serves the edge detector
      strb_s3 <= strb_s2;
    end
  end

  // high for one cycle after a strobe goes low
  assign strb_fall = strb_s3 & ~strb_s2;

  // either read strobe still held low
  assign rd_active = ~strb_s2[0] | ~strb_s2[2];

  ////////////////////////////////////////
  // request capture
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_valid <= 1'b0;
    end else begin
      req_valid <= |strb_fall;
    end
  end

  // payload, no reset
  always_ff @(posedge clk) begin
    if (|strb_fall) begin
      req.addr  <= snes_addr;
      req.pa    <= snes_pa;
      req.wdata <= snes_data_in;
      // a-bus wins if two strobes fall together
      if (strb_fall[0]) begin
        req.is_write <= 1'b0;
        req.is_bbus  <= 1'b0;
      end else if (strb_fall[1]) begin
        req.is_write <= 1'b1;
        req.is_bbus  <= 1'b0;
      end else if (strb_fall[2]) begin
        req.is_write <= 1'b0;
        req.is_bbus  <= 1'b1;
      end else begin
        req.is_write <= 1'b1;
        req.is_bbus  <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== cart_map_pkg.sv ====
`default_nettype none

package cart_map_pkg;

  ////////////////////////////////////////
  // mapper and state encodings
  ////////////////////////////////////////

  // mcu detected mapper, codes 3..6 decode to nothing mapped
  typedef enum logic [2:0] {
    map_hirom   = 3'd0,
    map_lorom   = 3'd1,
    map_exhirom = 3'd2,
    map_menu    = 3'd7
  } mapper_e;

  // sram access sequencer
  typedef enum logic [1:0] {
    seq_idle,
    seq_access,
    seq_done
  } seq_state_e;

  // bit positions inside featurebits
  localparam int feat_dspx = 0;
  localparam int feat_srtc = 2;
  localparam int feat_msu1 = 3;
  localparam int feat_213f = 4;

  ////////////////////////////////////////
  // bundles
  ////////////////////////////////////////

  // static cartridge configuration
  typedef struct packed {
    mapper_e     mapper;
    logic [7:0]  featurebits;
    logic [23:0] rom_mask;
    logic [23:0] saveram_mask;
  } map_cfg_t;

  // one captured snes bus cycle
  typedef struct packed {
    logic [23:0] addr;
    logic [7:0]  pa;
    logic        is_write;
    logic        is_bbus;
    logic [7:0]  wdata;
  } snes_req_t;

  // decoded view of one request
  typedef struct packed {
    logic [23:0] sram_addr;
    logic        is_rom;
    logic        is_saveram;
    logic        is_writable;
    logic        msu_sel;
    logic        srtc_sel;
    logic        dspx_sel;
    logic        dspx_a0;
    logic        r213f_sel;
    logic        cmd_rd_sel;
    logic        cmd_wr_sel;
  } map_result_t;

endpackage

`default_nettype wire
